/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_step_motor
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* rtl/motor_channel.sv */
`timescale 1ns/1ps
`include "step_motor_consts.svh"

module motor_channel (
	input logic ctl_clk,
	input logic resetn,
	speed_table_if.requester tbl,
	input step_motor_pkg::speed_addr_t table_len,
	input logic br_init,
	input step_motor_pkg::speed_t s_speed,
	input step_motor_pkg::step_t s_step,
	input step_motor_pkg::step_t s_stroke,
	input logic s_dir,
	input logic s_start,
	input logic s_stop,
	input step_motor_pkg::ms_t s_ms,
	input logic s_xen,
	input logic s_xrst,
	input logic m_zpd,
	output logic s_state,
	output logic s_zpsign,
	output logic s_tpsign,
	output step_motor_pkg::step_t s_position,
	output step_motor_pkg::speed_t s_rt_speed,
	output logic m_drive,
	output logic m_dir,
	output step_motor_pkg::ms_t m_ms,
	output logic m_xen,
	output logic m_xrst
);

	step_motor_pkg::chan_state_e state;
	step_motor_pkg::step_t n_steps;
	// Steps started so far in this move.
	step_motor_pkg::step_t k;
	step_motor_pkg::speed_t next_period;
	step_motor_pkg::speed_t fetched;
	step_motor_pkg::speed_t tick_cnt;
	logic [$clog2(`CLK_DIV)-1:0] presc;
	logic next_ready;
	logic stop_pend;
	logic accept;
	logic tick;
	logic step_end;
	logic halt;
	logic launch;

	// Ramp index: distance to the nearer end of the move, capped by the table.
	function automatic step_motor_pkg::speed_addr_t ramp_index(
		input step_motor_pkg::step_t idx,
		input step_motor_pkg::step_t total,
		input step_motor_pkg::speed_addr_t last
	);
		step_motor_pkg::step_t down;
		step_motor_pkg::step_t lo;
		down = total - idx - 1'b1;
		lo = (idx < down) ? idx : down;
		if (lo > step_motor_pkg::step_t'(last))
			lo = step_motor_pkg::step_t'(last);
		return step_motor_pkg::speed_addr_t'(lo);
	endfunction

	assign accept = (state == step_motor_pkg::idle) && s_start && !br_init;
	assign tick = (presc == `CLK_DIV - 1);
	assign step_end = (state == step_motor_pkg::run) && tick
		&& (tick_cnt == s_rt_speed - 1'b1);
	assign halt = (k >= n_steps) || stop_pend
		|| (!m_dir && s_position == s_stroke)
		|| (m_dir && s_zpsign);
	assign launch = !halt && next_ready
		&& ((state == step_motor_pkg::fetch) || step_end);

	assign s_state = (state != step_motor_pkg::idle);
	assign s_tpsign = (s_position == s_stroke);

	// Shortest step is two ticks, so the pulse has a low phase.
	always_comb begin
		fetched = (tbl.rd_data > s_speed) ? tbl.rd_data : s_speed;
		if (fetched < step_motor_pkg::speed_t'(2))
			fetched = step_motor_pkg::speed_t'(2);
	end

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			state <= step_motor_pkg::idle;
			n_steps <= '0;
			m_dir <= 1'b0;
			m_ms <= '0;
			stop_pend <= 1'b0;
		end else begin
			case (state)
				step_motor_pkg::idle: begin
					if (accept) begin
						state <= step_motor_pkg::fetch;
						n_steps <= s_step;
						m_dir <= s_dir;
						m_ms <= s_ms;
					end
				end
				step_motor_pkg::fetch: begin
					if (next_ready)
						state <= halt ? step_motor_pkg::idle : step_motor_pkg::run;
				end
				step_motor_pkg::run: begin
					if (step_end && halt)
						state <= step_motor_pkg::idle;
					else if (step_end && !next_ready)
						state <= step_motor_pkg::fetch;
				end
				default: state <= step_motor_pkg::idle;
			endcase
			if (state == step_motor_pkg::idle)
				stop_pend <= 1'b0;
			else if (s_stop)
				stop_pend <= 1'b1;
		end
	end

	// Next period is fetched while the current step runs.
	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			tbl.rd_req <= 1'b0;
			next_ready <= 1'b0;
		end else begin
			if (tbl.rd_valid) begin
				tbl.rd_req <= 1'b0;
				next_ready <= 1'b1;
			end
			if (accept) begin
				tbl.rd_req <= 1'b1;
				next_ready <= 1'b0;
			end else if (launch) begin
				tbl.rd_req <= (k + 1'b1 < n_steps);
				next_ready <= 1'b0;
			end
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (accept)
			tbl.rd_addr <= ramp_index(step_motor_pkg::step_t'(0), s_step, table_len);
		else if (launch)
			tbl.rd_addr <= ramp_index(k + 1'b1, n_steps, table_len);
	end

	always_ff @(posedge ctl_clk) begin
		if (tbl.rd_valid)
			next_period <= fetched;
	end

	// Step timer. Pulse covers the first tick.
	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			presc <= '0;
			tick_cnt <= '0;
			m_drive <= 1'b0;
			s_rt_speed <= '0;
			k <= '0;
		end else if (accept) begin
			k <= '0;
		end else if (launch) begin
			presc <= '0;
			tick_cnt <= '0;
			m_drive <= 1'b1;
			s_rt_speed <= next_period;
			k <= k + 1'b1;
		end else if (state == step_motor_pkg::run) begin
			presc <= tick ? '0 : presc + 1'b1;
			if (tick) begin
				m_drive <= 1'b0;
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (!resetn)
			s_position <= '0;
		else if (s_zpsign)
			s_position <= '0;
		else if (launch)
			s_position <= m_dir ? s_position - 1'b1 : s_position + 1'b1;
	end

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			s_zpsign <= 1'b0;
			m_xen <= 1'b0;
			m_xrst <= 1'b0;
		end else begin
			s_zpsign <= m_zpd;
			m_xen <= s_xen;
			m_xrst <= s_xrst;
		end
	end

endmodule

/* rtl/speed_table_arbiter.sv */
`timescale 1ns/1ps

module speed_table_arbiter (
	input logic ctl_clk,
	input logic resetn,
	speed_table_if.server ch0,
	speed_table_if.server ch1,
	speed_table_if.requester ram
);

	logic busy;
	logic owner;
	logic grant;
	logic grant_owner;

	// Owner also remembers who was served last.
	always_comb begin
		grant = 1'b0;
		grant_owner = owner;
		if (busy) begin
			// Hand over in the data cycle to save a turn.
			if (ram.rd_valid && (owner ? ch0.rd_req : ch1.rd_req)) begin
				grant = 1'b1;
				grant_owner = ~owner;
			end
		end else if (ch0.rd_req && ch1.rd_req) begin
			grant = 1'b1;
			grant_owner = ~owner;
		end else if (ch0.rd_req) begin
			grant = 1'b1;
			grant_owner = 1'b0;
		end else if (ch1.rd_req) begin
			grant = 1'b1;
			grant_owner = 1'b1;
		end
	end

	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			owner <= 1'b0;
		end else if (grant) begin
			busy <= 1'b1;
			owner <= grant_owner;
		end else if (ram.rd_valid) begin
			busy <= 1'b0;
		end
	end

	assign ram.rd_req = busy;
	assign ram.rd_addr = owner ? ch1.rd_addr : ch0.rd_addr;

	// Return path.
	assign ch0.rd_valid = ram.rd_valid && !owner;
	assign ch1.rd_valid = ram.rd_valid && owner;
	assign ch0.rd_data = ram.rd_data;
	assign ch1.rd_data = ram.rd_data;

endmodule

/* rtl/speed_table_if.sv */
`timescale 1ns/1ps

// Table read port. Request is a level held until rd_valid.
interface speed_table_if;

	logic rd_req;
	step_motor_pkg::speed_addr_t rd_addr;
	logic rd_valid;
	step_motor_pkg::speed_t rd_data;

	modport requester (
		output rd_req,
		output rd_addr,
		input rd_valid,
		input rd_data
	);

	modport server (
		input rd_req,
		input rd_addr,
		output rd_valid,
		output rd_data
	);

endinterface

/* rtl/speed_table_ram.sv */
`timescale 1ns/1ps
`include "step_motor_consts.svh"

module speed_table_ram (
	input logic ctl_clk,
	input logic resetn,
	input logic br_init,
	input logic br_wr_en,
	input step_motor_pkg::speed_t br_data,
	speed_table_if.server rd,
	output step_motor_pkg::speed_addr_t table_len
);

	step_motor_pkg::speed_t mem [`TABLE_DEPTH];
	step_motor_pkg::speed_addr_t wr_ptr;

	always_ff @(posedge ctl_clk) begin
		if (br_init && br_wr_en)
			mem[wr_ptr] <= br_data;
	end

	// Loader. table_len keeps the last index written.
	always_ff @(posedge ctl_clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			table_len <= '0;
		end else if (!br_init) begin
			wr_ptr <= '0;
		end else if (br_wr_en) begin
			table_len <= wr_ptr;
			// Pointer sticks at the last entry
			if (wr_ptr != `TABLE_DEPTH - 1)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// One read per request, never back to back.
	always_ff @(posedge ctl_clk) begin
		if (!resetn)
			rd.rd_valid <= 1'b0;
		else
			rd.rd_valid <= rd.rd_req && !rd.rd_valid;
	end

	always_ff @(posedge ctl_clk) begin
		if (rd.rd_req && !rd.rd_valid)
			rd.rd_data <= mem[rd.rd_addr];
	end

endmodule

/* rtl/step_motor_consts.svh */
`ifndef STEP_MOTOR_CONSTS_SVH
`define STEP_MOTOR_CONSTS_SVH

// Step counts, positions and strokes.
`define STEP_WIDTH 16

// Step periods, in speed ticks.
`define SPEED_WIDTH 16

`define SPEED_ADDR_WIDTH 4

// Microstep code passed to the driver.
`define MS_WIDTH 3

`define TABLE_DEPTH 16

// ctl_clk cycles per speed tick.
`define CLK_DIV 16

`endif

/* rtl/step_motor_pkg.sv */
`include "step_motor_consts.svh"

package step_motor_pkg;

	typedef logic [`STEP_WIDTH-1:0] step_t;

	typedef logic [`SPEED_WIDTH-1:0] speed_t;

	typedef logic [`SPEED_ADDR_WIDTH-1:0] speed_addr_t;

	typedef logic [`MS_WIDTH-1:0] ms_t;

	// Channel sequencer.
	typedef enum logic [1:0] {
		idle,
		fetch,
		run
	} chan_state_e;

endpackage

/* rtl/step_motor_top.sv */
`timescale 1ns/1ps

module step_motor_top (
	input logic ctl_clk,
	input logic resetn,
	input logic br_init,
	input logic br_wr_en,
	input step_motor_pkg::speed_t br_data,

	input step_motor_pkg::speed_t s0_speed,
	input step_motor_pkg::step_t s0_step,
	input step_motor_pkg::step_t s0_stroke,
	input logic s0_dir,
	input logic s0_start,
	input logic s0_stop,
	input step_motor_pkg::ms_t s0_ms,
	input logic s0_xen,
	input logic s0_xrst,
	input logic m0_zpd,
	output logic s0_state,
	output logic s0_zpsign,
	output logic s0_tpsign,
	output step_motor_pkg::step_t s0_position,
	output step_motor_pkg::speed_t s0_rt_speed,
	output logic m0_drive,
	output logic m0_dir,
	output step_motor_pkg::ms_t m0_ms,
	output logic m0_xen,
	output logic m0_xrst,

	input step_motor_pkg::speed_t s1_speed,
	input step_motor_pkg::step_t s1_step,
	input step_motor_pkg::step_t s1_stroke,
	input logic s1_dir,
	input logic s1_start,
	input logic s1_stop,
	input step_motor_pkg::ms_t s1_ms,
	input logic s1_xen,
	input logic s1_xrst,
	input logic m1_zpd,
	output logic s1_state,
	output logic s1_zpsign,
	output logic s1_tpsign,
	output step_motor_pkg::step_t s1_position,
	output step_motor_pkg::speed_t s1_rt_speed,
	output logic m1_drive,
	output logic m1_dir,
	output step_motor_pkg::ms_t m1_ms,
	output logic m1_xen,
	output logic m1_xrst
);

	step_motor_pkg::speed_addr_t table_len;

	speed_table_if ch0_tbl ();
	speed_table_if ch1_tbl ();
	speed_table_if ram_tbl ();

	speed_table_ram u_ram (
		.ctl_clk  (ctl_clk),
		.resetn   (resetn),
		.br_init  (br_init),
		.br_wr_en (br_wr_en),
		.br_data  (br_data),
		.rd       (ram_tbl.server),
		.table_len(table_len)
	);

	speed_table_arbiter u_arb (
		.ctl_clk(ctl_clk),
		.resetn (resetn),
		.ch0    (ch0_tbl.server),
		.ch1    (ch1_tbl.server),
		.ram    (ram_tbl.requester)
	);

	motor_channel u_ch0 (
		.ctl_clk    (ctl_clk),
		.resetn     (resetn),
		.tbl        (ch0_tbl.requester),
		.table_len  (table_len),
		.br_init    (br_init),
		.s_speed    (s0_speed),
		.s_step     (s0_step),
		.s_stroke   (s0_stroke),
		.s_dir      (s0_dir),
		.s_start    (s0_start),
		.s_stop     (s0_stop),
		.s_ms       (s0_ms),
		.s_xen      (s0_xen),
		.s_xrst     (s0_xrst),
		.m_zpd      (m0_zpd),
		.s_state    (s0_state),
		.s_zpsign   (s0_zpsign),
		.s_tpsign   (s0_tpsign),
		.s_position (s0_position),
		.s_rt_speed (s0_rt_speed),
		.m_drive    (m0_drive),
		.m_dir      (m0_dir),
		.m_ms       (m0_ms),
		.m_xen      (m0_xen),
		.m_xrst     (m0_xrst)
	);

	motor_channel u_ch1 (
		.ctl_clk    (ctl_clk),
		.resetn     (resetn),
		.tbl        (ch1_tbl.requester),
		.table_len  (table_len),
		.br_init    (br_init),
		.s_speed    (s1_speed),
		.s_step     (s1_step),
		.s_stroke   (s1_stroke),
		.s_dir      (s1_dir),
		.s_start    (s1_start),
		.s_stop     (s1_stop),
		.s_ms       (s1_ms),
		.s_xen      (s1_xen),
		.s_xrst     (s1_xrst),
		.m_zpd      (m1_zpd),
		.s_state    (s1_state),
		.s_zpsign   (s1_zpsign),
		.s_tpsign   (s1_tpsign),
		.s_position (s1_position),
		.s_rt_speed (s1_rt_speed),
		.m_drive    (m1_drive),
		.m_dir      (m1_dir),
		.m_ms       (m1_ms),
		.m_xen      (m1_xen),
		.m_xrst     (m1_xrst)
	);

endmodule

/* sim.f */
+incdir+rtl
rtl/step_motor_pkg.sv
rtl/speed_table_if.sv
rtl/speed_table_ram.sv
rtl/speed_table_arbiter.sv
rtl/motor_channel.sv
rtl/step_motor_top.sv
verification/tb_step_motor.sv

/* verification/tb_step_motor.sv */
`timescale 1ns/1ps
`include "step_motor_consts.svh"

module tb_step_motor;

	logic ctl_clk;
	logic resetn;
	logic br_init;
	logic br_wr_en;
	step_motor_pkg::speed_t br_data;

	step_motor_pkg::speed_t s0_speed, s1_speed;
	step_motor_pkg::step_t s0_step, s1_step;
	step_motor_pkg::step_t s0_stroke, s1_stroke;
	logic s0_dir, s0_start, s0_stop, s0_xen, s0_xrst, m0_zpd;
	logic s1_dir, s1_start, s1_stop, s1_xen, s1_xrst, m1_zpd;
	step_motor_pkg::ms_t s0_ms, s1_ms;

	logic s0_state, s0_zpsign, s0_tpsign, m0_drive, m0_dir, m0_xen, m0_xrst;
	logic s1_state, s1_zpsign, s1_tpsign, m1_drive, m1_dir, m1_xen, m1_xrst;
	step_motor_pkg::step_t s0_position, s1_position;
	step_motor_pkg::speed_t s0_rt_speed, s1_rt_speed;
	step_motor_pkg::ms_t m0_ms, m1_ms;

	// Model of the loaded table.
	step_motor_pkg::speed_t ref_table [`TABLE_DEPTH];
	int ref_last = 0;

	integer seed;
	int cycle = 0;
	int cycle_limit = 0;
	int rise0 [$];
	int rise1 [$];
	logic drive0_q = 1'b0;
	logic drive1_q = 1'b0;
	int n_fwd;
	int n_both;

	step_motor_top dut0 (.*);

	always #2 ctl_clk = ~ctl_clk;

	always @(posedge ctl_clk) begin
		cycle <= cycle + 1;
		if (cycle_limit > 0 && cycle > cycle_limit)
			abort_run("timeout: the run went past its cycle limit");
	end

	// Rising drive pin edges are sampled on the falling clock.
	always @(negedge ctl_clk) begin
		if (m0_drive && !drive0_q)
			rise0.push_back(cycle);
		if (m1_drive && !drive1_q)
			rise1.push_back(cycle);
		drive0_q = m0_drive;
		drive1_q = m1_drive;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check(input string name, input logic [31:0] got, input int expected);
		if (got !== expected)
			abort_run($sformatf("error: time %0t, %s: got %0d, expected %0d",
				$time, name, got, expected));
	endtask

	task automatic next_edge();
		@(posedge ctl_clk);
		#1;
	endtask

	// Nearer end of the move, capped by the table, floored by the speed.
	function automatic int expected_period(input int k, input int n, input int speed);
		int idx;
		int p;
		idx = k;
		if (n - 1 - k < idx)
			idx = n - 1 - k;
		if (ref_last < idx)
			idx = ref_last;
		p = ref_table[idx];
		if (speed > p)
			p = speed;
		return p;
	endfunction

	task automatic wait_idle(input int ch, input int bound);
		int n;
		n = 0;
		next_edge();
		while ((ch == 0) ? s0_state : s1_state) begin
			if (n >= bound)
				abort_run($sformatf("channel %0d still busy after %0d cycles", ch, bound));
			n++;
			next_edge();
		end
	endtask

	task automatic wait_pulses(input int ch, input int count, input int bound);
		int n;
		n = 0;
		while (((ch == 0) ? rise0.size() : rise1.size()) < count) begin
			if (n >= bound)
				abort_run($sformatf("channel %0d gave fewer than %0d pulses", ch, count));
			n++;
			next_edge();
		end
	endtask

	task automatic check_gaps(input int ch, input int n, input int speed);
		int gap;
		int cnt;
		cnt = (ch == 0) ? rise0.size() : rise1.size();
		for (int i = 1; i < cnt; i++) begin
			gap = (ch == 0) ? rise0[i] - rise0[i-1] : rise1[i] - rise1[i-1];
			check($sformatf("m%0d_drive gap %0d", ch, i), gap,
				expected_period(i - 1, n, speed) * `CLK_DIV);
		end
	endtask

	task automatic set_command(input int ch, input int steps, input int speed,
		input logic dir, input int ms);
		next_edge();
		if (ch == 0) begin
			s0_step = step_motor_pkg::step_t'(steps);
			s0_speed = step_motor_pkg::speed_t'(speed);
			s0_dir = dir;
			s0_ms = step_motor_pkg::ms_t'(ms);
		end else begin
			s1_step = step_motor_pkg::step_t'(steps);
			s1_speed = step_motor_pkg::speed_t'(speed);
			s1_dir = dir;
			s1_ms = step_motor_pkg::ms_t'(ms);
		end
	endtask

	task automatic pulse_start(input logic go0, input logic go1);
		next_edge();
		s0_start = go0;
		s1_start = go1;
		next_edge();
		s0_start = 1'b0;
		s1_start = 1'b0;
	endtask

	task automatic load_table();
		next_edge();
		br_init = 1'b1;
		for (int i = 0; i < 8; i++) begin
			br_wr_en = 1'b1;
			br_data = step_motor_pkg::speed_t'(30 - 2 * i);
			ref_table[i] = step_motor_pkg::speed_t'(30 - 2 * i);
			next_edge();
		end
		br_wr_en = 1'b0;
		ref_last = 7;
		next_edge();
		br_init = 1'b0;
		next_edge();
	endtask

	task automatic test_reset();
		next_edge();
		check("m0_drive", m0_drive, 0);
		check("m1_drive", m1_drive, 0);
		check("s0_state", s0_state, 0);
		check("s1_state", s1_state, 0);
		check("s0_tpsign", s0_tpsign, 0);
		check("s1_tpsign", s1_tpsign, 0);
		check("s0_zpsign", s0_zpsign, 0);
		check("s1_zpsign", s1_zpsign, 0);
		check("s0_position", s0_position, 0);
		check("s1_position", s1_position, 0);
	endtask

	task automatic test_driver_enables();
		next_edge();
		s0_xen = 1'b1;
		s1_xrst = 1'b1;
		next_edge();
		check("m0_xen", m0_xen, 1);
		check("m0_xrst", m0_xrst, 0);
		check("m1_xen", m1_xen, 0);
		check("m1_xrst", m1_xrst, 1);
		s0_xen = 1'b0;
		s0_xrst = 1'b1;
		s1_xen = 1'b1;
		s1_xrst = 1'b0;
		next_edge();
		check("m0_xen", m0_xen, 0);
		check("m0_xrst", m0_xrst, 1);
		check("m1_xen", m1_xen, 1);
		check("m1_xrst", m1_xrst, 0);
	endtask

	task automatic test_forward();
		rise0.delete();
		set_command(0, n_fwd, 15, 1'b0, 2);
		pulse_start(1'b1, 1'b0);
		check("s0_state", s0_state, 1);
		wait_idle(0, n_fwd * 30 * `CLK_DIV + 200);
		check("m0_drive pulse count", rise0.size(), n_fwd);
		check("m0_dir", m0_dir, 0);
		check("m0_ms", m0_ms, 2);
		check("s0_position", s0_position, n_fwd);
		check("s0_rt_speed", s0_rt_speed, expected_period(n_fwd - 1, n_fwd, 15));
		check_gaps(0, n_fwd, 15);
	endtask

	task automatic test_stroke();
		int start_pos;
		start_pos = s0_position;
		rise0.delete();
		next_edge();
		s0_stroke = step_motor_pkg::step_t'(start_pos + 2);
		set_command(0, 5, 15, 1'b0, 2);
		pulse_start(1'b1, 1'b0);
		wait_idle(0, 5 * 30 * `CLK_DIV + 200);
		check("m0_drive pulse count", rise0.size(), 2);
		check("s0_position", s0_position, start_pos + 2);
		check("s0_tpsign", s0_tpsign, 1);
		check_gaps(0, 5, 15);
	endtask

	task automatic test_zero();
		rise0.delete();
		set_command(0, 20, 15, 1'b1, 2);
		pulse_start(1'b1, 1'b0);
		wait_pulses(0, 4, 4 * 30 * `CLK_DIV + 200);
		m0_zpd = 1'b1;
		wait_idle(0, 20 * 30 * `CLK_DIV + 200);
		check("s0_position", s0_position, 0);
		check("s0_zpsign", s0_zpsign, 1);
		check("m0_dir", m0_dir, 1);
		// Idle window of two longest steps.
		repeat (2 * 30 * `CLK_DIV) next_edge();
		check("m0_drive pulse count", rise0.size(), 4);
		check_gaps(0, 20, 15);
		m0_zpd = 1'b0;
		s0_stroke = 16'hffff;
		next_edge();
		next_edge();
	endtask

	task automatic test_both();
		int cnt1;
		rise0.delete();
		rise1.delete();
		set_command(0, n_both, 15, 1'b0, 2);
		set_command(1, 30, 2, 1'b0, 1);
		pulse_start(1'b1, 1'b1);
		wait_pulses(1, 5, 5 * 30 * `CLK_DIV + 200);
		s1_stop = 1'b1;
		next_edge();
		s1_stop = 1'b0;
		wait_idle(1, 30 * 30 * `CLK_DIV + 200);
		wait_idle(0, n_both * 30 * `CLK_DIV + 200);
		cnt1 = rise1.size();
		if (cnt1 < 5 || cnt1 > 6)
			abort_run($sformatf("error: time %0t, m1_drive pulse count: got %0d, expected 5 or 6",
				$time, cnt1));
		check("s1_position", s1_position, cnt1);
		check("m1_dir", m1_dir, 0);
		check("m1_ms", m1_ms, 1);
		check("s1_rt_speed", s1_rt_speed, expected_period(cnt1 - 1, 30, 2));
		check_gaps(1, 30, 2);
		check("m0_drive pulse count", rise0.size(), n_both);
		check("s0_position", s0_position, n_both);
		check("m0_dir", m0_dir, 0);
		check("s0_rt_speed", s0_rt_speed, expected_period(n_both - 1, n_both, 15));
		check_gaps(0, n_both, 15);
	endtask

	initial begin
		seed = 32'h6d5963b5;
		n_fwd = 6 + ($unsigned($random(seed)) % 9);
		n_both = 6 + ($unsigned($random(seed)) % 9);
		cycle_limit = (n_fwd + 5 + 20 + n_both + 30) * 30 * `CLK_DIV + 2000;

		ctl_clk = 1'b0;
		resetn = 1'b0;
		br_init = 1'b0;
		br_wr_en = 1'b0;
		br_data = '0;
		{s0_speed, s1_speed, s0_step, s1_step} = '0;
		s0_stroke = 16'hffff;
		s1_stroke = 16'hffff;
		{s0_dir, s0_start, s0_stop, s0_xen, s0_xrst, m0_zpd} = '0;
		{s1_dir, s1_start, s1_stop, s1_xen, s1_xrst, m1_zpd} = '0;
		s0_ms = '0;
		s1_ms = '0;

		repeat (16) @(posedge ctl_clk);
		#1;
		resetn = 1'b1;

		test_reset();
		test_driver_enables();
		load_table();
		test_forward();
		test_stroke();
		test_zero();
		test_both();

		$display("RESULT: PASS");
		$finish;
	end

endmodule
